// File: filelist.f
common/mem_bus_pkg.sv
common/ab_test_pkg.sv
ab_tester/ab_sequencer.sv
ab_tester/ab_addr_gen.sv
ab_tester/ab_resp_checker.sv
logic/ab_tester_top.sv
sim/mem_fault_model.sv
sim/ab_tester_sva.sv
sim/tb_ab_tester.sv

// File: sim/tb_ab_tester.sv
/*
    Testbench of the address-bus tester.
    Runs the walking-one test on the memory model with no fault, each
    stuck address bit and each adjacent short, first on a quiet memory
    and then with random busy and latency, then a cleared run and
    back-to-back runs. Fault counts are compared with a software replay,
    and each accepted memory request with the test order.
*/

module tb_ab_tester;
    import mem_bus_pkg::*;

    localparam int unsigned AW         = 6;
    localparam int unsigned DW         = 8;
    localparam int unsigned RST_CYCLES = 10;
    localparam int unsigned B2B        = 3;     // Back-to-back runs
    // Requests of one test, writes then reads
    localparam int unsigned REQS  = (AW + 1) + 3 * AW + AW + AW * (AW + 1);
    localparam int unsigned TESTS = 6 * AW + 2 + B2B;

    localparam logic [1:0] FK_NONE   = 2'd0;
    localparam logic [1:0] FK_STUCK0 = 2'd1;
    localparam logic [1:0] FK_STUCK1 = 2'd2;
    localparam logic [1:0] FK_SHORT  = 2'd3;

    logic          reset;      // Clock
    logic          clk;        // Reset
    logic          start;
    logic          clear;
    logic          ready;
    logic          fault;
    logic          done;
    logic [AW-1:0] m_addr;
    mem_op_e       m_op;
    logic [DW-1:0] m_wdat;
    logic [DW-1:0] m_rdat;
    logic          m_rval;
    logic          m_busy;
    logic [1:0]    fault_kind;
    int            fault_bit;
    logic          rand_en;
    logic          mem_quiet;

    int unsigned   exp_q [$];  // Expected count per started run
    mem_op_e       op_q [$];   // Expected requests, issue order
    logic [AW-1:0] addr_q [$];
    logic [DW-1:0] wdat_q [$];
    int unsigned   fault_cnt;
    int unsigned   done_cnt;

    ab_tester_top #(.AWIDTH(AW), .DWIDTH(DW)) i_dut (
        .reset(reset), .clk(clk), .start(start), .clear(clear),
        .ready(ready), .fault(fault), .done(done),
        .m_addr(m_addr), .m_op(m_op), .m_wdat(m_wdat),
        .m_rdat(m_rdat), .m_rval(m_rval), .m_busy(m_busy)
    );

    mem_fault_model #(.AWIDTH(AW), .DWIDTH(DW)) i_mem (
        .reset(reset), .clk(clk), .m_addr(m_addr), .m_op(m_op),
        .m_wdat(m_wdat), .m_rdat(m_rdat), .m_rval(m_rval), .m_busy(m_busy),
        .fault_kind(fault_kind), .fault_bit(fault_bit), .rand_en(rand_en),
        .quiet(mem_quiet)
    );

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [DW-1:0] alt_pattern();
        logic [DW-1:0] p;
        for (int i = 0; i < DW; i++) begin
            p[i] = (i % 2 == 1);   // Bit 0 cleared
        end
        return p;
    endfunction

    function automatic logic [AW-1:0] faulty_addr(logic [AW-1:0] a, logic [1:0] kind, int b);
        logic [AW-1:0] f;
        f = a;
        if (kind == FK_STUCK0) f[b] = 1'b0;
        if (kind == FK_STUCK1) f[b] = 1'b1;
        if (kind == FK_SHORT) begin
            f[b]   = a[b] & a[b+1];     // Shorted lines read as AND
            f[b+1] = a[b] & a[b+1];
        end
        return f;
    endfunction

    function automatic int unsigned expected_faults(logic [1:0] kind, int b);
        logic [DW-1:0] img [2**AW];
        logic [DW-1:0] pat;
        int unsigned   bad;
        bad = 0;
        pat = alt_pattern();
        for (int k = 0; k < AW; k++) img[faulty_addr(AW'(1 << k), kind, b)] = pat;
        img[faulty_addr('0, kind, b)] = ~pat;
        for (int k = 0; k < AW; k++) begin
            if (img[faulty_addr(AW'(1 << k), kind, b)] !== pat) bad++;
        end
        for (int j = 0; j < AW; j++) begin     // Phase 2, one round per target
            img[faulty_addr('0, kind, b)] = pat;
            img[faulty_addr(AW'(1 << j), kind, b)] = ~pat;
            if (img[faulty_addr('0, kind, b)] !== pat) bad++;
            for (int k = 0; k < AW; k++) begin
                if (img[faulty_addr(AW'(1 << k), kind, b)] !== ((k == j) ? ~pat : pat)) bad++;
            end
            img[faulty_addr(AW'(1 << j), kind, b)] = pat;
        end
        return bad;
    endfunction

    task automatic push_request(mem_op_e op, logic [AW-1:0] a, logic [DW-1:0] d);
        op_q.push_back(op);
        addr_q.push_back(a);
        wdat_q.push_back(d);
    endtask

    // Request stream of one whole test
    task automatic queue_requests();
        logic [DW-1:0] pat;
        pat = alt_pattern();
        for (int k = 0; k < AW; k++) push_request(op_write, AW'(1 << k), pat);
        push_request(op_write, '0, ~pat);
        for (int k = 0; k < AW; k++) push_request(op_read, AW'(1 << k), '0);
        for (int j = 0; j < AW; j++) begin
            push_request(op_write, '0, pat);
            push_request(op_write, AW'(1 << j), ~pat);
            push_request(op_read, '0, '0);
            for (int k = 0; k < AW; k++) push_request(op_read, AW'(1 << k), '0);
            push_request(op_write, AW'(1 << j), pat);
        end
    endtask

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic fail_run(string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_count(string name, int unsigned got, int unsigned want);
        if (got !== want) begin
            fail_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, want));
        end
    endtask

    task automatic check_flag(string name, logic got, logic want);
        if (got !== want) begin
            fail_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, want));
        end
    endtask

    task automatic check_op(string name, mem_op_e got, mem_op_e want);
        if (got !== want) begin
            fail_run($sformatf("MISMATCH at %0t: %s got %s expected %s",
                               $time, name, got.name(), want.name()));
        end
    endtask

    task automatic check_addr(string name, logic [AW-1:0] got, logic [AW-1:0] want);
        if (got !== want) begin
            fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h",
                               $time, name, got, want));
        end
    endtask

    task automatic check_data(string name, logic [DW-1:0] got, logic [DW-1:0] want);
        if (got !== want) begin
            fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h",
                               $time, name, got, want));
        end
    endtask

    // Request about to be accepted on the next edge
    task automatic check_request();
        mem_op_e       op;
        logic [AW-1:0] a;
        logic [DW-1:0] d;
        if (op_q.size() == 0) begin
            fail_run("memory request with no test running");
        end else begin
            op = op_q.pop_front();
            a  = addr_q.pop_front();
            d  = wdat_q.pop_front();
            check_op("m_op", m_op, op);
            check_addr("m_addr", m_addr, a);
            if (op == op_write) check_data("m_wdat", m_wdat, d);
        end
    endtask

    // Checks each accepted request, counts fault pulses, checks the count at done
    always @(negedge reset) begin
        if (clk || clear) begin
            fault_cnt = 0;
            op_q.delete();
            addr_q.delete();
            wdat_q.delete();
        end else begin
            if (i_dut.i_sva.error_count != 0) begin
                fail_run("a protocol assertion failed");
            end
            if (m_op != op_idle && !m_busy) begin
                check_request();
            end
            if (fault) fault_cnt++;
            if (done && exp_q.size() == 0) begin
                fail_run("done pulse with no test running");
            end else if (done) begin
                check_count("fault count", fault_cnt, exp_q.pop_front());
                fault_cnt = 0;
                done_cnt++;
            end
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic pulse_start();
        while (!ready) begin
            @(posedge reset);
            #1;
        end
        queue_requests();
        start = 1'b1;
        @(posedge reset);
        #1;
        start = 1'b0;
    endtask

    task automatic run_test(logic [1:0] kind, int b, logic rnd);
        int unsigned runs;
        int unsigned want;
        runs = done_cnt;
        want = expected_faults(kind, b);
        if (kind != FK_NONE && want == 0) fail_run("reference sees no fault for an injected fault");
        fault_kind = kind;
        fault_bit  = b;
        rand_en    = rnd;
        exp_q.push_back(want);
        pulse_start();
        wait (done_cnt != runs);
        @(posedge reset);
        #1;
        check_flag("ready", ready, 1'b1);   // Cycle after done
    endtask

    initial begin
        reset = 1'b0;
        forever #2 reset = ~reset;
    end

    initial begin
        repeat (RST_CYCLES + 20 * REQS * TESTS) @(posedge reset);
        fail_run("Timeout, the tests did not finish in time");
    end

    initial begin
        int unsigned rvals;
        int unsigned runs;
        void'($urandom(32'h90ebe708));
        clk        = 1'b1;
        start      = 1'b0;
        clear      = 1'b0;
        fault_kind = FK_NONE;
        fault_bit  = 0;
        rand_en    = 1'b0;
        fault_cnt  = 0;
        done_cnt   = 0;
        repeat (RST_CYCLES) @(posedge reset);
        #1;
        clk = 1'b0;
        check_flag("ready", ready, 1'b1);
        check_flag("fault", fault, 1'b0);
        check_flag("done", done, 1'b0);
        check_op("m_op", m_op, op_idle);

        for (int pass = 0; pass < 2; pass++) begin     // Quiet memory, then random
            run_test(FK_NONE, 0, pass[0]);
            for (int b = 0; b < AW; b++) run_test(FK_STUCK0, b, pass[0]);
            for (int b = 0; b < AW; b++) run_test(FK_STUCK1, b, pass[0]);
            for (int b = 0; b < AW - 1; b++) run_test(FK_SHORT, b, pass[0]);
        end

        // Clear partway through the read phase
        runs       = done_cnt;
        fault_kind = FK_STUCK0;
        fault_bit  = 2;
        rand_en    = 1'b1;
        pulse_start();
        rvals = 0;
        while (rvals < 2 * AW) begin
            @(negedge reset);
            if (m_rval) rvals++;
        end
        @(posedge reset);
        #1;
        clear = 1'b1;
        @(posedge reset);
        #1;
        clear = 1'b0;
        check_flag("ready", ready, 1'b1);
        while (!mem_quiet) @(negedge reset);  // Drop reads still in flight
        @(posedge reset);
        #1;
        check_count("done count", done_cnt, runs);
        run_test(FK_STUCK0, 2, 1'b1);

        for (int n = 0; n < B2B; n++) run_test(FK_SHORT, 1, 1'b1);

        if (exp_q.size() != 0 || op_q.size() != 0 || done_cnt != TESTS - 1
                || i_dut.i_sva.error_count != 0) begin
            fail_run("runs left unfinished or assertion errors seen");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule : tb_ab_tester

// File: sim/ab_tester_sva.sv
/*
    Protocol checks for the address-bus tester, bound to its top level.
    Single-cycle done, fault only while a test runs, request held
    under back-pressure, ready low while a request is out.
*/

module ab_tester_sva
    import mem_bus_pkg::*;
#(
    parameter int unsigned AWIDTH = 8,
    parameter int unsigned DWIDTH = 8
)
(
    input  logic                reset,      // Clock
    input  logic                clk,        // Async reset, active high
    input  logic                clear,
    input  logic                ready,
    input  logic                fault,
    input  logic                done,
    input  logic                m_busy,
    input  mem_op_e             m_op,
    input  logic [AWIDTH-1:0]   m_addr,
    input  logic [DWIDTH-1:0]   m_wdat
);

    int unsigned error_count = 0;   // Count of failed assertions

    done_one_cycle: assert property (@(posedge reset) disable iff (clk) done |=> !done)
        else begin
            $error("done high for two cycles");
            error_count++;
        end

    // Faults belong to the reads of a running test
    fault_during_test: assert property (@(posedge reset) disable iff (clk)
        fault |-> !ready)
        else begin
            $error("fault while no test is running");
            error_count++;
        end

    request_held: assert property (@(posedge reset) disable iff (clk)
        (m_busy && m_op != op_idle && !clear)
            |=> $stable(m_op) && $stable(m_addr) && $stable(m_wdat))
        else begin
            $error("request changed while busy");
            error_count++;
        end

    busy_not_ready: assert property (@(posedge reset) disable iff (clk)
        (m_op != op_idle) |-> !ready)
        else begin
            $error("ready high with a request out");
            error_count++;
        end

endmodule : ab_tester_sva

bind ab_tester_top ab_tester_sva #(.AWIDTH(AWIDTH), .DWIDTH(DWIDTH)) i_sva (
    .reset  (reset),
    .clk    (clk),
    .clear  (clear),
    .ready  (ready),
    .fault  (fault),
    .done   (done),
    .m_busy (m_busy),
    .m_op   (m_op),
    .m_addr (m_addr),
    .m_wdat (m_wdat)
);

// File: sim/mem_fault_model.sv
/*
    Behavioral memory for the address-bus tester testbench.
    Accepts requests while busy is low and returns reads in order.
    Busy and read latency can be random, and an address fault can be
    injected: one bit stuck at 0 or 1, or two adjacent bits shorted by AND.
*/

module mem_fault_model
    import mem_bus_pkg::*;
#(
    parameter int unsigned AWIDTH = 8,
    parameter int unsigned DWIDTH = 8
)
(
    input  logic                reset,      // Clock
    input  logic                clk,        // Async reset, active high
    input  logic [AWIDTH-1:0]   m_addr,
    input  mem_op_e             m_op,
    input  logic [DWIDTH-1:0]   m_wdat,
    output logic [DWIDTH-1:0]   m_rdat,
    output logic                m_rval,
    output logic                m_busy,
    input  logic [1:0]          fault_kind, // 0 none, 1 stuck 0, 2 stuck 1, 3 short
    input  int                  fault_bit,  // Lower bit of a short
    input  logic                rand_en,    // Random busy and latency
    output logic                quiet       // No read in flight
);

    logic [DWIDTH-1:0] mem [2**AWIDTH];
    logic [DWIDTH-1:0] rd_q [$];            // Read data, issue order
    int unsigned       due_q [$];           // Cycle each read returns
    int unsigned       cyc;
    int unsigned       due;

    // Address as the faulty decoder sees it
    function automatic logic [AWIDTH-1:0] decode(logic [AWIDTH-1:0] a);
        logic [AWIDTH-1:0] f;
        f = a;
        case (fault_kind)
            2'd1: f[fault_bit] = 1'b0;
            2'd2: f[fault_bit] = 1'b1;
            2'd3: begin
                f[fault_bit]     = a[fault_bit] & a[fault_bit+1];
                f[fault_bit+1]   = a[fault_bit] & a[fault_bit+1];
            end
            default: f = a;
        endcase
        return f;
    endfunction

    initial begin
        m_rdat = '0;
        m_rval = 1'b0;
        m_busy = 1'b0;
        quiet  = 1'b1;
    end

    always @(posedge reset or posedge clk) begin
        if (clk) begin
            rd_q.delete();
            due_q.delete();
            cyc = 0;
            for (int a = 0; a < 2**AWIDTH; a++) begin
                mem[a] = DWIDTH'(a * 37 + 5);   // Fill differs per address
            end
            m_rval = 1'b0;
            m_busy = 1'b0;
            quiet  = 1'b1;
        end else begin
            cyc++;
            if (m_op != op_idle && !m_busy) begin
                if (m_op == op_write) begin
                    mem[decode(m_addr)] = m_wdat;
                end else begin
                    due = cyc + (rand_en ? $urandom_range(3, 0) : 0);
                    if (due_q.size() != 0 && due <= due_q[$]) begin
                        due = due_q[$] + 1;         // Keep issue order
                    end
                    rd_q.push_back(mem[decode(m_addr)]);
                    due_q.push_back(due);
                end
            end
            #1;
            m_rval = 1'b0;
            if (due_q.size() != 0 && due_q[0] <= cyc) begin
                void'(due_q.pop_front());
                m_rdat = rd_q.pop_front();
                m_rval = 1'b1;
            end
            m_busy = rand_en ? ($urandom_range(3, 0) == 0) : 1'b0;  // About one in four
            quiet  = (due_q.size() == 0) && !m_rval;
        end
    end

endmodule : mem_fault_model

// File: logic/ab_tester_top.sv
/*
    Top level of the memory address-bus tester.
    Connects the sequencer, address generator and response checker
    to the control port and the memory request port.
    Widths are set here and passed down.
*/

module ab_tester_top
    import mem_bus_pkg::*, ab_test_pkg::*;
#(
    parameter int unsigned AWIDTH = DEF_AWIDTH,
    parameter int unsigned DWIDTH = DEF_DWIDTH
)
(
    input  logic                reset,      // Clock
    input  logic                clk,        // Async reset, active high

    // Control
    input  logic                start,
    input  logic                clear,
    output logic                ready,
    output logic                fault,
    output logic                done,

    // Memory master
    output logic [AWIDTH-1:0]   m_addr,
    output mem_op_e             m_op,
    output logic [DWIDTH-1:0]   m_wdat,
    input  logic [DWIDTH-1:0]   m_rdat,
    input  logic                m_rval,
    input  logic                m_busy
);

    logic              data_inv;
    addr_step_e        addr_step;
    logic [1:0]        addr_sel;
    logic              last_walk;
    logic              last_target;
    logic              chk_start;
    logic              chk_idle;
    logic [DWIDTH-1:0] pattern;

    ab_sequencer i_seq (
        .reset       (reset),
        .clk         (clk),
        .clear       (clear),
        .start       (start),
        .m_busy      (m_busy),
        .last_walk   (last_walk),
        .last_target (last_target),
        .chk_idle    (chk_idle),
        .ready       (ready),
        .m_op        (m_op),
        .data_inv    (data_inv),
        .addr_step   (addr_step),
        .addr_sel    (addr_sel),
        .chk_start   (chk_start),
        .done        (done)
    );

    ab_addr_gen #(.AWIDTH(AWIDTH)) i_addr_gen (
        .reset       (reset),
        .clk         (clk),
        .addr_step   (addr_step),
        .addr_sel    (addr_sel),
        .m_busy      (m_busy),
        .m_addr      (m_addr),
        .last_walk   (last_walk),
        .last_target (last_target)
    );

    ab_resp_checker #(.AWIDTH(AWIDTH), .DWIDTH(DWIDTH)) i_checker (
        .reset       (reset),
        .clk         (clk),
        .clear       (clear),
        .chk_start   (chk_start),
        .m_rval      (m_rval),
        .m_rdat      (m_rdat),
        .fault       (fault),
        .chk_idle    (chk_idle)
    );

    // ------------------------------
    // Write data
    // ------------------------------
    always_comb begin
        for (int i = 0; i < DWIDTH; i++) begin
            pattern[i] = i[0];     // 0101... from bit 0
        end
    end

    assign m_wdat = data_inv ? ~pattern : pattern;     // Antipattern on marks

endmodule : ab_tester_top

// File: ab_tester/ab_resp_checker.sv
/*
    Read response checker of the address-bus tester.
    Counts read responses on its own and rebuilds the expected word
    for each one from the test order: a round of AWIDTH pattern reads,
    then per target a read of zero and a walking-one sweep.
    Pulses fault on a mismatch and reports idle after the final read.
*/

module ab_resp_checker #(
    parameter int unsigned AWIDTH = 8,     // Address bits
    parameter int unsigned DWIDTH = 8      // Data bits
)
(
    input  logic                reset,      // Clock
    input  logic                clk,        // Async reset, active high

    input  logic                clear,
    input  logic                chk_start,  // New test begins
    input  logic                m_rval,
    input  logic [DWIDTH-1:0]   m_rdat,

    output logic                fault,
    output logic                chk_idle
);

    localparam int unsigned CW = $clog2(AWIDTH + 1);

    logic [DWIDTH-1:0] pattern;
    logic [DWIDTH-1:0] expected;
    logic [CW-1:0]     rd_idx;     // Read inside the round
    logic [CW-1:0]     round;      // 0 is phase 1, j+1 is target j
    logic              active;
    logic              exp_inv;
    logic              round_end;
    logic              last_read;

    // Alternating bits, bit 0 cleared
    always_comb begin
        for (int i = 0; i < DWIDTH; i++) begin
            pattern[i] = i[0];
        end
    end

    // ------------------------------
    // Expected word
    // ------------------------------
    // Phase 2 index 0 is address zero, index k is bit k-1
    assign exp_inv   = (round != '0) && (rd_idx == round);    // Marked target
    assign expected  = exp_inv ? ~pattern : pattern;
    assign round_end = (round == '0) ? (rd_idx == CW'(AWIDTH - 1))
                                     : (rd_idx == CW'(AWIDTH));
    assign last_read = round_end && (round == CW'(AWIDTH));

    // ------------------------------
    // Response counters
    // ------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            active <= 1'b0;
            rd_idx <= '0;
            round  <= '0;
        end else if (clear) begin
            active <= 1'b0;
            rd_idx <= '0;
            round  <= '0;
        end else if (chk_start) begin
            active <= 1'b1;
            rd_idx <= '0;
            round  <= '0;
        end else if (active & m_rval) begin
            if (last_read) begin
                active <= 1'b0;            // Whole test read back
                rd_idx <= '0;
                round  <= '0;
            end else if (round_end) begin
                rd_idx <= '0;
                round  <= round + 1'b1;
            end else begin
                rd_idx <= rd_idx + 1'b1;
            end
        end
    end

    // One-cycle fault per bad word
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            fault <= 1'b0;
        end else if (clear) begin
            fault <= 1'b0;
        end else begin
            fault <= active & m_rval & (m_rdat != expected);
        end
    end

    assign chk_idle = ~active;

endmodule : ab_resp_checker

// File: ab_tester/ab_addr_gen.sv
/*
    Address generator of the address-bus tester.
    A walking-one register sweeps the address bits, a target register
    selects the marked address of each phase-2 round.
    Driven by step commands from the sequencer.
*/

module ab_addr_gen
    import ab_test_pkg::*;
#(
    parameter int unsigned AWIDTH = 8      // Address bits, at least 2
)
(
    input  logic                reset,      // Clock
    input  logic                clk,        // Async reset, active high

    input  addr_step_e          addr_step,
    input  logic [1:0]          addr_sel,
    input  logic                m_busy,

    output logic [AWIDTH-1:0]   m_addr,
    output logic                last_walk,
    output logic                last_target
);

    localparam logic [AWIDTH-1:0] FIRST = AWIDTH'(1);   // Bit 0 set

    logic [AWIDTH-1:0] walk_r;
    logic [AWIDTH-1:0] tgt_r;
    logic              adv;

    // Steps follow accepted requests; load_first only comes with no request out
    assign adv = ~m_busy | (addr_step == step_load_first);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            walk_r <= FIRST;
            tgt_r  <= FIRST;
        end else if (adv) begin
            case (addr_step)
                step_load_first: begin
                    walk_r <= FIRST;
                    tgt_r  <= FIRST;
                end
                step_walk:        walk_r <= {walk_r[AWIDTH-2:0], 1'b0};
                step_restart:     walk_r <= FIRST;
                step_next_target: tgt_r  <= {tgt_r[AWIDTH-2:0], tgt_r[AWIDTH-1]};
                default:          walk_r <= walk_r;    // Hold
            endcase
        end
    end

    assign last_walk   = walk_r[AWIDTH-1];
    assign last_target = tgt_r[AWIDTH-1];

    // ------------------------------
    // Address source mux
    // ------------------------------
    always_comb begin
        case (addr_sel)
            ADDR_SEL_WALK:   m_addr = walk_r;
            ADDR_SEL_TARGET: m_addr = tgt_r;
            default:         m_addr = '0;   // Address zero
        endcase
    end

endmodule : ab_addr_gen

// File: ab_tester/ab_sequencer.sv
/*
    Control FSM of the address-bus tester.
    Orders the writes and reads of the walking-one test, steers the
    address generator and the write data polarity, and raises done
    once the response checker has seen the final read.
    Advances only on cycles where the memory accepts the request.
*/

module ab_sequencer
    import mem_bus_pkg::*, ab_test_pkg::*;
(
    input  logic        reset,          // Clock
    input  logic        clk,            // Async reset, active high

    input  logic        clear,          // Back to idle, no done
    input  logic        start,          // Sampled while ready
    input  logic        m_busy,         // Request not accepted this edge
    input  logic        last_walk,      // Walking register at top bit
    input  logic        last_target,    // Target register at top bit
    input  logic        chk_idle,       // Final read response seen

    output logic        ready,
    output mem_op_e     m_op,
    output logic        data_inv,       // Antipattern on write data
    output addr_step_e  addr_step,
    output logic [1:0]  addr_sel,
    output logic        chk_start,      // Arms the checker
    output logic        done
);

    seq_state_e state;
    logic       done_r;
    addr_step_e walk_step;

    // ------------------------------
    // Status
    // ------------------------------
    assign ready     = (state == st_idle) & ~done_r;   // Stays low through done
    assign chk_start = ready & start;
    assign done      = done_r;

    // Sweep step, wraps to bit 0 after the top address
    assign walk_step = last_walk ? step_restart : step_walk;

    // ------------------------------
    // Per-state request decode
    // ------------------------------
    always_comb begin
        m_op      = op_idle;
        data_inv  = 1'b0;
        addr_sel  = ADDR_SEL_ZERO;
        addr_step = step_hold;
        case (state)
            st_idle, st_wait_resp: begin
                addr_step = step_load_first;   // Park on first address
            end
            st_p1_fill, st_p1_read, st_p2_read_all: begin
                m_op      = (state == st_p1_fill) ? op_write : op_read;
                addr_sel  = ADDR_SEL_WALK;
                addr_step = walk_step;
            end
            st_p1_zero, st_p2_zero: begin
                m_op     = op_write;
                data_inv = (state == st_p1_zero);  // Phase 1 marks zero
            end
            st_p2_mark: begin
                m_op     = op_write;
                data_inv = 1'b1;
                addr_sel = ADDR_SEL_TARGET;
            end
            st_p2_read_zero: begin
                m_op = op_read;
            end
            st_p2_restore: begin
                m_op      = op_write;
                addr_sel  = ADDR_SEL_TARGET;
                addr_step = step_next_target;  // Next round's target
            end
            default: begin
                m_op = op_idle;
            end
        endcase
    end

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state <= st_idle;
        end else if (clear) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:         if (ready & start)        state <= st_p1_fill;
                st_p1_fill:      if (~m_busy & last_walk)  state <= st_p1_zero;
                st_p1_zero:      if (~m_busy)              state <= st_p1_read;
                st_p1_read:      if (~m_busy & last_walk)  state <= st_p2_zero;
                st_p2_zero:      if (~m_busy)              state <= st_p2_mark;
                st_p2_mark:      if (~m_busy)              state <= st_p2_read_zero;
                st_p2_read_zero: if (~m_busy)              state <= st_p2_read_all;
                st_p2_read_all:  if (~m_busy & last_walk)  state <= st_p2_restore;
                st_p2_restore: begin
                    if (~m_busy) begin
                        // Last target done, wait for the reads in flight
                        state <= last_target ? st_wait_resp : st_p2_zero;
                    end
                end
                st_wait_resp:    if (chk_idle)             state <= st_idle;
                default:                                   state <= st_idle;
            endcase
        end
    end

    // Single-cycle done as the FSM leaves wait_resp
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            done_r <= 1'b0;
        end else if (clear) begin
            done_r <= 1'b0;
        end else begin
            done_r <= (state == st_wait_resp) & chk_idle;
        end
    end

endmodule : ab_sequencer

// File: common/ab_test_pkg.sv
/*
    Address-bus test definitions.
    Sequencer state encoding, the step command from the sequencer
    to the address generator, and the address source select codes.
    Imported by the sequencer, the address generator and the top level.
*/

package ab_test_pkg;

    // ------------------------------
    // Sequencer states
    // ------------------------------
    typedef enum logic [3:0] {
        st_idle,            // Waiting for start
        st_p1_fill,         // Pattern to every walking-one address
        st_p1_zero,         // Antipattern to address zero
        st_p1_read,         // Read every walking-one address
        st_p2_zero,         // Pattern to zero
        st_p2_mark,         // Antipattern to target j
        st_p2_read_zero,    // Read address zero
        st_p2_read_all,     // Read every walking-one address
        st_p2_restore,      // Pattern back to target j
        st_wait_resp        // Drain outstanding reads
    } seq_state_e;

    // ------------------------------
    // Address generator commands
    // ------------------------------
    typedef enum logic [2:0] {
        step_hold,          // Keep both registers
        step_load_first,    // Both registers to bit 0
        step_walk,          // Walking register one bit left
        step_next_target,   // Rotate target register
        step_restart        // Walking register back to bit 0
    } addr_step_e;

    // Address source select
    localparam logic [1:0] ADDR_SEL_ZERO   = 2'd0;
    localparam logic [1:0] ADDR_SEL_WALK   = 2'd1;
    localparam logic [1:0] ADDR_SEL_TARGET = 2'd2;

endpackage : ab_test_pkg

// File: common/mem_bus_pkg.sv
/*
    Memory request port definitions.
    Shared by the tester RTL and the testbench memory model:
    the request opcode on m_op and the default bus widths
    that the top level starts from.
*/

package mem_bus_pkg;

    // ------------------------------
    // Default widths
    // ------------------------------
    localparam int unsigned DEF_AWIDTH = 8;    // Address bits
    localparam int unsigned DEF_DWIDTH = 8;    // Data bits

    // ------------------------------
    // Request opcode
    // ------------------------------
    // Any value other than op_idle is a request
    // Accepted on a rising edge with m_busy low
    typedef enum logic [1:0] {
        op_idle  = 2'b00,   // No request
        op_write = 2'b01,   // Write m_wdat to m_addr
        op_read  = 2'b10    // Read m_addr, data returns with m_rval
    } mem_op_e;

endpackage : mem_bus_pkg
